// ==== all.f ====
common/udp_echo_cfg_pkg.sv
common/udp_frame_pkg.sv
hw/echo/stream_fifo.sv
hw/echo/udp_echo_ctrl.sv
hw/udp_echo_top.sv
testbench/tb_udp_echo.sv

// ==== common/udp_echo_cfg_pkg.sv ====
//////////////////////////////////////////////////
// UDP echo configuration
// Default echo port, payload FIFO depth and the
// header field widths shared by the frame types
//////////////////////////////////////////////////

package udp_echo_cfg_pkg;

    // Header field widths
    localparam int IP_ADDR_W  = 32;
    localparam int UDP_PORT_W = 16;
    localparam int UDP_LEN_W  = 16;

    // Payload beat geometry
    localparam int DATA_BYTES = 8;
    localparam int DATA_W     = DATA_BYTES * 8;

    // Datagrams to this port are echoed, all others drained
    localparam logic [UDP_PORT_W-1:0] ECHO_PORT = 16'd1234;

    // Reply payload buffering in beats
    localparam int PAYLOAD_FIFO_DEPTH = 64;

endpackage

// ==== common/udp_frame_pkg.sv ====
//////////////////////////////////////////////////
// UDP frame types
// Header field types and the payload beat that
// travels on the receive and reply streams
//////////////////////////////////////////////////

package udp_frame_pkg;

    typedef logic [udp_echo_cfg_pkg::IP_ADDR_W-1:0]  ip_addr_t;
    typedef logic [udp_echo_cfg_pkg::UDP_PORT_W-1:0] udp_port_t;
    typedef logic [udp_echo_cfg_pkg::UDP_LEN_W-1:0]  udp_len_t;

    // One payload beat, byte enables per data byte
    typedef struct packed {
        logic [udp_echo_cfg_pkg::DATA_W-1:0]     data;
        logic [udp_echo_cfg_pkg::DATA_BYTES-1:0] keep;
        // End of datagram
        logic                                    last;
        // Error flag from the receive side
        logic                                    user;
    } payload_beat_t;

endpackage

// ==== hw/echo/stream_fifo.sv ====
//////////////////////////////////////////////////
// Stream FIFO
// Circular buffer for valid/ready beats with a
// registered output stage, any beat type
//////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_fifo #(
    parameter type beat_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  logic  clk,
    input  logic  rst,

    input  beat_t in_beat,
    input  logic  in_valid,
    output logic  in_ready,

    output beat_t out_beat,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    beat_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic out_load;
    logic mem_empty;
    logic bypass;
    logic mem_wr;
    logic mem_rd;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign push      = in_valid && in_ready;
    assign out_load  = !out_valid || out_ready;
    assign mem_empty = (count == '0);

    // Empty buffer and free output stage, beat skips the memory
    assign bypass = push && out_load && mem_empty;
    assign mem_wr = push && !bypass;
    assign mem_rd = out_load && !mem_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (mem_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + CNT_W'(mem_wr) - CNT_W'(mem_rd);
            if (out_load) begin
                out_valid <= mem_rd || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= in_beat;
        end
        // Oldest stored beat goes first
        if (mem_rd) begin
            out_beat <= mem[rd_ptr];
        end else if (bypass) begin
            out_beat <= in_beat;
        end
    end

endmodule

// ==== hw/echo/udp_echo_ctrl.sv ====
//////////////////////////////////////////////////
// UDP echo controller
// Matches the destination port, turns the header
// around and passes or drains the payload
//////////////////////////////////////////////////

`timescale 1ns/1ps

module udp_echo_ctrl #(
    parameter udp_frame_pkg::udp_port_t ECHO_PORT = udp_echo_cfg_pkg::ECHO_PORT
) (
    input  logic                          clk,
    input  logic                          rst,

    // Receive header
    input  logic                          s_udp_hdr_valid,
    output logic                          s_udp_hdr_ready,
    input  udp_frame_pkg::ip_addr_t       s_udp_ip_source_ip,
    input  udp_frame_pkg::udp_port_t      s_udp_source_port,
    input  udp_frame_pkg::udp_port_t      s_udp_dest_port,
    input  udp_frame_pkg::udp_len_t       s_udp_length,

    // Receive payload
    input  udp_frame_pkg::payload_beat_t  s_payload,
    input  logic                          s_payload_valid,
    output logic                          s_payload_ready,

    // Reply header
    output logic                          m_udp_hdr_valid,
    input  logic                          m_udp_hdr_ready,
    output udp_frame_pkg::ip_addr_t       m_udp_ip_dest_ip,
    output udp_frame_pkg::udp_port_t      m_udp_source_port,
    output udp_frame_pkg::udp_port_t      m_udp_dest_port,
    output udp_frame_pkg::udp_len_t       m_udp_length,

    // Gated payload towards the reply FIFO
    output udp_frame_pkg::payload_beat_t  fifo_beat,
    output logic                          fifo_valid,
    input  logic                          fifo_ready
);

    logic port_match;
    logic match_reg;
    logic drop_reg;
    logic last_xfer;

    assign port_match = (s_udp_dest_port == ECHO_PORT);

    // Header path is combinational
    // Other ports are accepted at once and get no reply
    assign m_udp_hdr_valid = s_udp_hdr_valid && port_match;
    assign s_udp_hdr_ready = m_udp_hdr_ready || !port_match;

    // Reply goes back to the sender with the ports swapped
    assign m_udp_ip_dest_ip  = s_udp_ip_source_ip;
    assign m_udp_source_port = s_udp_dest_port;
    assign m_udp_dest_port   = s_udp_source_port;
    assign m_udp_length      = s_udp_length;

    assign last_xfer = s_payload_valid && s_payload_ready && s_payload.last;

    // Per-frame decision, taken while the first beat waits
    // and held until the last beat is gone
    always_ff @(posedge clk) begin
        if (rst) begin
            match_reg <= 1'b0;
            drop_reg  <= 1'b0;
        end else if (!s_payload_valid || last_xfer) begin
            match_reg <= 1'b0;
            drop_reg  <= 1'b0;
        end else if (!match_reg && !drop_reg) begin
            match_reg <= port_match;
            drop_reg  <= !port_match;
        end
    end

    // Matching payload flows into the FIFO under its back-pressure
    assign fifo_beat  = s_payload;
    assign fifo_valid = s_payload_valid && match_reg;

    // Dropped beats are taken every cycle, nothing before a decision
    assign s_payload_ready = (fifo_ready && match_reg) || drop_reg;

endmodule

// ==== hw/udp_echo_top.sv ====
//////////////////////////////////////////////////
// UDP echo top level
// Echo controller feeding the reply payload FIFO,
// with the first payload byte of each reply on led
//////////////////////////////////////////////////

`timescale 1ns/1ps

module udp_echo_top #(
    parameter udp_frame_pkg::udp_port_t ECHO_PORT  = udp_echo_cfg_pkg::ECHO_PORT,
    parameter int                       FIFO_DEPTH = udp_echo_cfg_pkg::PAYLOAD_FIFO_DEPTH
) (
    input  logic                          clk,
    input  logic                          rst,

    // Receive header
    input  logic                          s_udp_hdr_valid,
    output logic                          s_udp_hdr_ready,
    input  udp_frame_pkg::ip_addr_t       s_udp_ip_source_ip,
    input  udp_frame_pkg::udp_port_t      s_udp_source_port,
    input  udp_frame_pkg::udp_port_t      s_udp_dest_port,
    input  udp_frame_pkg::udp_len_t       s_udp_length,

    // Receive payload
    input  udp_frame_pkg::payload_beat_t  s_payload,
    input  logic                          s_payload_valid,
    output logic                          s_payload_ready,

    // Reply header
    output logic                          m_udp_hdr_valid,
    input  logic                          m_udp_hdr_ready,
    output udp_frame_pkg::ip_addr_t       m_udp_ip_dest_ip,
    output udp_frame_pkg::udp_port_t      m_udp_source_port,
    output udp_frame_pkg::udp_port_t      m_udp_dest_port,
    output udp_frame_pkg::udp_len_t       m_udp_length,

    // Reply payload
    output udp_frame_pkg::payload_beat_t  m_payload,
    output logic                          m_payload_valid,
    input  logic                          m_payload_ready,

    output logic [7:0]                    led
);

    udp_frame_pkg::payload_beat_t fifo_beat;
    logic                         fifo_valid;
    logic                         fifo_ready;

    // Set while the next reply beat opens a frame
    logic                         first_beat;

    udp_echo_ctrl #(
        .ECHO_PORT (ECHO_PORT)
    ) i_echo_ctrl (
        .clk                (clk),
        .rst                (rst),
        .s_udp_hdr_valid    (s_udp_hdr_valid),
        .s_udp_hdr_ready    (s_udp_hdr_ready),
        .s_udp_ip_source_ip (s_udp_ip_source_ip),
        .s_udp_source_port  (s_udp_source_port),
        .s_udp_dest_port    (s_udp_dest_port),
        .s_udp_length       (s_udp_length),
        .s_payload          (s_payload),
        .s_payload_valid    (s_payload_valid),
        .s_payload_ready    (s_payload_ready),
        .m_udp_hdr_valid    (m_udp_hdr_valid),
        .m_udp_hdr_ready    (m_udp_hdr_ready),
        .m_udp_ip_dest_ip   (m_udp_ip_dest_ip),
        .m_udp_source_port  (m_udp_source_port),
        .m_udp_dest_port    (m_udp_dest_port),
        .m_udp_length       (m_udp_length),
        .fifo_beat          (fifo_beat),
        .fifo_valid         (fifo_valid),
        .fifo_ready         (fifo_ready)
    );

    stream_fifo #(
        .beat_t (udp_frame_pkg::payload_beat_t),
        .DEPTH  (FIFO_DEPTH)
    ) i_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (fifo_beat),
        .in_valid  (fifo_valid),
        .in_ready  (fifo_ready),
        .out_beat  (m_payload),
        .out_valid (m_payload_valid),
        .out_ready (m_payload_ready)
    );

    // Low byte of the first transferred beat of each reply frame
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= 8'h00;
        end else if (m_payload_valid && m_payload_ready) begin
            if (first_beat) begin
                led <= m_payload.data[7:0];
            end
            first_beat <= m_payload.last;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UDP echo testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_udp_echo \
    -f all.f \
    -o tb_udp_echo

./obj_dir/tb_udp_echo | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi

echo "Simulation passed"

// ==== testbench/tb_udp_echo.sv ====
//////////////////////////////////////////////////
// UDP echo testbench
// Drives frames from the test data file, checks
// reply headers, reply payload and the led value
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_udp_echo;

    localparam int CLK_HALF     = 50;
    localparam int DRIVE_DELAY  = 5;
    localparam int FRAME_CYCLES = 4000;
    localparam udp_frame_pkg::udp_port_t ECHO_PORT = udp_echo_cfg_pkg::ECHO_PORT;

    logic                         clk;
    logic                         rst;
    logic                         s_udp_hdr_valid;
    logic                         s_udp_hdr_ready;
    udp_frame_pkg::ip_addr_t      s_udp_ip_source_ip;
    udp_frame_pkg::udp_port_t     s_udp_source_port;
    udp_frame_pkg::udp_port_t     s_udp_dest_port;
    udp_frame_pkg::udp_len_t      s_udp_length;
    udp_frame_pkg::payload_beat_t s_payload;
    logic                         s_payload_valid;
    logic                         s_payload_ready;
    logic                         m_udp_hdr_valid;
    logic                         m_udp_hdr_ready;
    udp_frame_pkg::ip_addr_t      m_udp_ip_dest_ip;
    udp_frame_pkg::udp_port_t     m_udp_source_port;
    udp_frame_pkg::udp_port_t     m_udp_dest_port;
    udp_frame_pkg::udp_len_t      m_udp_length;
    udp_frame_pkg::payload_beat_t m_payload;
    logic                         m_payload_valid;
    logic                         m_payload_ready;
    logic [7:0]                   led;

    logic [63:0] tdata [0:255];
    int          rd_pos;
    int          frame_count;
    int          errors;
    int          tests_run;
    int          tests_failed;
    integer      seed;
    logic        bp_enable;

    // Expected reply headers as {dest ip, source port, dest port, length}
    logic [79:0]                  exp_hdrs [$];
    udp_frame_pkg::payload_beat_t exp_beats [$];
    logic                         reply_first;
    logic                         led_pending;
    logic [7:0]                   exp_led;

    udp_echo_top #(
        .ECHO_PORT  (ECHO_PORT),
        .FIFO_DEPTH (udp_echo_cfg_pkg::PAYLOAD_FIFO_DEPTH)
    ) i_dut (
        .clk                (clk),
        .rst                (rst),
        .s_udp_hdr_valid    (s_udp_hdr_valid),
        .s_udp_hdr_ready    (s_udp_hdr_ready),
        .s_udp_ip_source_ip (s_udp_ip_source_ip),
        .s_udp_source_port  (s_udp_source_port),
        .s_udp_dest_port    (s_udp_dest_port),
        .s_udp_length       (s_udp_length),
        .s_payload          (s_payload),
        .s_payload_valid    (s_payload_valid),
        .s_payload_ready    (s_payload_ready),
        .m_udp_hdr_valid    (m_udp_hdr_valid),
        .m_udp_hdr_ready    (m_udp_hdr_ready),
        .m_udp_ip_dest_ip   (m_udp_ip_dest_ip),
        .m_udp_source_port  (m_udp_source_port),
        .m_udp_dest_port    (m_udp_dest_port),
        .m_udp_length       (m_udp_length),
        .m_payload          (m_payload),
        .m_payload_valid    (m_payload_valid),
        .m_payload_ready    (m_payload_ready),
        .led                (led)
    );

    always #CLK_HALF clk = ~clk;

    // Random reply back-pressure for frames flagged in the data file
    initial begin
        m_payload_ready = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (bp_enable) begin
                m_payload_ready = (($random(seed) & 3) != 0);
            end else begin
                m_payload_ready = 1'b1;
            end
        end
    end

    task automatic check_reply_header();
        logic [79:0] exp;
        assert (exp_hdrs.size() != 0) else begin
            $display("Reply header appeared for a frame that must not be echoed");
            errors++;
        end
        if (exp_hdrs.size() != 0) begin
            exp = exp_hdrs.pop_front();
            assert (m_udp_ip_dest_ip == exp[79:48]) else begin
                $display("[FAIL] m_udp_ip_dest_ip got %h expected %h",
                         m_udp_ip_dest_ip, exp[79:48]);
                errors++;
            end
            assert (m_udp_source_port == exp[47:32]) else begin
                $display("[FAIL] m_udp_source_port got %h expected %h",
                         m_udp_source_port, exp[47:32]);
                errors++;
            end
            assert (m_udp_dest_port == exp[31:16]) else begin
                $display("[FAIL] m_udp_dest_port got %h expected %h",
                         m_udp_dest_port, exp[31:16]);
                errors++;
            end
            assert (m_udp_length == exp[15:0]) else begin
                $display("[FAIL] m_udp_length got %h expected %h", m_udp_length, exp[15:0]);
                errors++;
            end
        end
    endtask

    task automatic check_reply_beat();
        udp_frame_pkg::payload_beat_t exp;
        assert (exp_beats.size() != 0) else begin
            $display("Reply beat appeared while no echoed beat was pending");
            errors++;
        end
        if (exp_beats.size() != 0) begin
            exp = exp_beats.pop_front();
            assert (m_payload.data == exp.data) else begin
                $display("[FAIL] m_payload.data got %h expected %h", m_payload.data, exp.data);
                errors++;
            end
            assert (m_payload.keep == exp.keep) else begin
                $display("[FAIL] m_payload.keep got %h expected %h", m_payload.keep, exp.keep);
                errors++;
            end
            assert (m_payload.last == exp.last) else begin
                $display("[FAIL] m_payload.last got %h expected %h", m_payload.last, exp.last);
                errors++;
            end
            assert (m_payload.user == exp.user) else begin
                $display("[FAIL] m_payload.user got %h expected %h", m_payload.user, exp.user);
                errors++;
            end
            if (reply_first) begin
                exp_led = exp.data[7:0];
            end
            reply_first = exp.last;
            if (exp.last) begin
                led_pending = 1'b1;
            end
        end
    endtask

    task automatic check_led_value();
        if (led_pending) begin
            assert (led == exp_led) else begin
                $display("[FAIL] led got %h expected %h", led, exp_led);
                errors++;
            end
            led_pending = 1'b0;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_led_value();
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                check_reply_header();
            end
            if (m_payload_valid && m_payload_ready) begin
                check_reply_beat();
            end
        end
    end

    task automatic send_header(input udp_frame_pkg::ip_addr_t ip,
                               input udp_frame_pkg::udp_port_t sport,
                               input udp_frame_pkg::udp_port_t dport,
                               input udp_frame_pkg::udp_len_t len,
                               input logic echoed);
        @(posedge clk);
        #DRIVE_DELAY;
        s_udp_ip_source_ip = ip;
        s_udp_source_port  = sport;
        s_udp_dest_port    = dport;
        s_udp_length       = len;
        s_udp_hdr_valid    = 1'b1;
        // Reply side stalls for the first cycle of every header
        m_udp_hdr_ready    = 1'b0;
        @(negedge clk);
        assert (m_udp_hdr_valid == echoed) else begin
            $display("[FAIL] m_udp_hdr_valid got %h expected %h", m_udp_hdr_valid, echoed);
            errors++;
        end
        assert (s_udp_hdr_ready == !echoed) else begin
            $display("[FAIL] s_udp_hdr_ready got %h expected %h", s_udp_hdr_ready, !echoed);
            errors++;
        end
        while (!s_udp_hdr_ready) begin
            @(posedge clk);
            #DRIVE_DELAY;
            m_udp_hdr_ready = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        // Fields stay put for the payload decision
        s_udp_hdr_valid = 1'b0;
        m_udp_hdr_ready = 1'b1;
    endtask

    task automatic send_beat(input udp_frame_pkg::payload_beat_t beat);
        s_payload       = beat;
        s_payload_valid = 1'b1;
        @(negedge clk);
        while (!s_payload_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        s_payload_valid = 1'b0;
    endtask

    task automatic run_frame(input int idx);
        udp_frame_pkg::ip_addr_t      src_ip;
        udp_frame_pkg::udp_port_t     src_port;
        udp_frame_pkg::udp_port_t     dst_port;
        udp_frame_pkg::udp_len_t      length;
        udp_frame_pkg::payload_beat_t beat;
        logic                         echoed;
        int                           n_beats;
        int                           errors_before;
        errors_before = errors;
        src_ip    = tdata[rd_pos][31:0];
        src_port  = tdata[rd_pos + 1][15:0];
        dst_port  = tdata[rd_pos + 2][15:0];
        length    = tdata[rd_pos + 3][15:0];
        bp_enable = tdata[rd_pos + 4][0];
        n_beats   = int'(tdata[rd_pos + 5]);
        rd_pos    = rd_pos + 6;
        echoed    = (dst_port == ECHO_PORT);
        // Reply goes back to the sender with ports swapped and length kept
        if (echoed) begin
            exp_hdrs.push_back({src_ip, dst_port, src_port, length});
        end
        send_header(src_ip, src_port, dst_port, length, echoed);
        for (int b = 0; b < n_beats; b++) begin
            beat.data = tdata[rd_pos];
            beat.keep = tdata[rd_pos + 1][7:0];
            beat.last = tdata[rd_pos + 2][0];
            beat.user = tdata[rd_pos + 3][0];
            rd_pos    = rd_pos + 4;
            if (echoed) begin
                exp_beats.push_back(beat);
            end
            send_beat(beat);
        end
        while (exp_beats.size() != 0 || exp_hdrs.size() != 0 || led_pending) begin
            @(negedge clk);
        end
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("Frame %0d to port %0d, %0d beats, %s, back-pressure %0d: %s",
                 idx, dst_port, n_beats, echoed ? "echoed" : "dropped", bp_enable,
                 (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        clk                = 1'b0;
        rst                = 1'b1;
        s_udp_hdr_valid    = 1'b0;
        s_udp_ip_source_ip = '0;
        s_udp_source_port  = '0;
        s_udp_dest_port    = '0;
        s_udp_length       = '0;
        s_payload          = '0;
        s_payload_valid    = 1'b0;
        m_udp_hdr_ready    = 1'b1;
        seed               = 32'hd43b_7e9d;
        bp_enable          = 1'b0;
        errors             = 0;
        tests_run          = 0;
        tests_failed       = 0;
        reply_first        = 1'b1;
        led_pending        = 1'b0;
        exp_led            = 8'h00;
        $readmemh("testbench/udp_echo_testdata.txt", tdata);
        frame_count = int'(tdata[0]);
        rd_pos      = 1;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        @(negedge clk);
        assert (m_udp_hdr_valid == 1'b0) else begin
            $display("[FAIL] m_udp_hdr_valid got %h expected %h", m_udp_hdr_valid, 1'b0);
            errors++;
        end
        assert (m_payload_valid == 1'b0) else begin
            $display("[FAIL] m_payload_valid got %h expected %h", m_payload_valid, 1'b0);
            errors++;
        end
        assert (s_payload_ready == 1'b0) else begin
            $display("[FAIL] s_payload_ready got %h expected %h", s_payload_ready, 1'b0);
            errors++;
        end
        assert (led == 8'h00) else begin
            $display("[FAIL] led got %h expected %h", led, 8'h00);
            errors++;
        end
        tests_run++;
        if (errors != 0) begin
            tests_failed++;
        end
        $display("Reset state: %s", (errors == 0) ? "passed" : "failed");

        for (int f = 1; f <= frame_count; f++) begin
            run_frame(f);
        end

        // Idle tail so late or repeated reply beats still get flagged
        repeat (8) @(negedge clk);

        $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #1;
        repeat ((frame_count + 1) * FRAME_CYCLES) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles",
                 (frame_count + 1) * FRAME_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== testbench/udp_echo_testdata.txt ====
// Word 0 is the frame count, then per frame: source IP, source port, dest port,
// length, back-pressure flag, beat count; then per beat: data keep last user
6
c0a80a02 c350 04d2 001e 0 3
0011223344556677 ff 0 0
8899aabbccddeeff ff 0 0
00000a0b0c0d0e0f 3f 1 0
c0a80a03 1388 04d3 0018 0 2
deadbeefcafef00d ff 0 0
0123456789abcdef ff 1 0
0a000001 0035 04d2 000b 1 1
0000000000a5b6c7 07 1 1
ac100005 8001 04d2 0030 1 5
1111111111111111 ff 0 0
2222222222222222 ff 0 0
3333333333333333 ff 0 1
4444444444444444 ff 0 0
5555555555555555 ff 1 0
c0a80a04 9000 0007 0014 1 2
f0f1f2f3f4f5f6f7 ff 0 0
00000000fafbfcfd 0f 1 0
c0a80a02 c351 04d2 0027 1 4
a1a2a3a4a5a6a7a8 ff 0 0
b1b2b3b4b5b6b7b8 ff 0 0
c1c2c3c4c5c6c7c8 ff 0 0
00d1d2d3d4d5d6d7 7f 1 0
